//--- prf_pkg.sv
`default_nettype none

package prf_pkg;

    localparam int xlen       = 64;
    localparam int preg_width = 7;  // up to 128 physical registers
    localparam int areg_width = 5;

    typedef logic [xlen-1:0]       data_t;
    typedef logic [preg_width-1:0] preg_t;
    typedef logic [areg_width-1:0] areg_t;

    // one read port request
    typedef struct packed {
        logic  en;
        preg_t addr;
    } prf_rd_req_t;

    // one write port request
    typedef struct packed {
        logic  we;
        preg_t addr;
        data_t data;
    } prf_wr_req_t;

    // one retiring instruction's destination mapping
    typedef struct packed {
        logic  valid;
        areg_t areg;
        preg_t preg;
    } rat_commit_t;

    typedef enum logic {
        st_clear = 1'b0,  // sweeping rows to zero
        st_ready = 1'b1
    } mpram_state_e;

endpackage

`default_nettype wire

//--- mpram.sv
`timescale 1ns/100ps
`default_nettype none

module mpram
    import prf_pkg::*;
#(
    parameter int read_port  = 4,
    parameter int write_port = 4,
    parameter int depth      = 128,
    parameter int bank_size  = 64
) (
    input  logic        clk,
    input  logic        rst_n,
    input  prf_rd_req_t rd_req [read_port],
    output data_t       rd_data [read_port],
    input  prf_wr_req_t wr_req [write_port],
    output logic        ready
);

    localparam int bank_num   = depth / bank_size;
    localparam int row_width  = (bank_size > 1) ? $clog2(bank_size) : 1;
    localparam int bank_width = (bank_num > 1) ? $clog2(bank_num) : 1;

    typedef logic [row_width-1:0]  row_t;
    typedef logic [bank_width-1:0] bank_t;

    data_t        mem [bank_num][bank_size];
    mpram_state_e state;
    row_t         clr_row;  // row being cleared in every bank

    // upper address bits pick the bank
    function automatic bank_t bank_of(preg_t addr);
        return bank_t'(addr / bank_size);
    endfunction

    function automatic row_t row_of(preg_t addr);
        return row_t'(addr % bank_size);
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= st_clear;
            clr_row <= '0;
        end else if (state == st_clear) begin
            if (clr_row == row_t'(bank_size - 1)) begin
                state <= st_ready;  // last row done
            end
            clr_row <= clr_row + 1'b1;
        end
    end

    assign ready = (state == st_ready);

    // the sweep blocks writes and the highest write port wins
    always_ff @(posedge clk) begin
        if (state == st_clear) begin
            for (int b = 0; b < bank_num; b++) begin
                mem[b][clr_row] <= '0;
            end
        end else begin
            for (int w = 0; w < write_port; w++) begin
                if (wr_req[w].we) begin
                    mem[bank_of(wr_req[w].addr)][row_of(wr_req[w].addr)] <= wr_req[w].data;
                end
            end
        end
    end

    // registered reads return old data on a same-edge write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < read_port; r++) begin
                rd_data[r] <= '0;
            end
        end else if (state == st_ready) begin
            for (int r = 0; r < read_port; r++) begin
                if (rd_req[r].en) begin
                    rd_data[r] <= mem[bank_of(rd_req[r].addr)][row_of(rd_req[r].addr)];
                end
            end
        end
    end

    for (genvar r = 0; r < read_port; r++) begin : g_rd_chk
        a_rd_ready: assert property (
            @(posedge clk) disable iff (!rst_n)
            rd_req[r].en |-> ready
        ) else $error("read port %0d enabled during clear sweep", r);

        a_rd_range: assert property (
            @(posedge clk) disable iff (!rst_n)
            rd_req[r].en |-> (rd_req[r].addr < depth)
        ) else $error("read port %0d address %0d out of range", r, rd_req[r].addr);
    end

    for (genvar w = 0; w < write_port; w++) begin : g_wr_chk
        a_wr_range: assert property (
            @(posedge clk) disable iff (!rst_n)
            wr_req[w].we |-> (wr_req[w].addr < depth)
        ) else $error("write port %0d address %0d out of range", w, wr_req[w].addr);
    end

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile
    import prf_pkg::*;
#(
    parameter int read_port  = 4,
    parameter int write_port = 4,
    parameter int preg_size  = 128
) (
    input  logic        clk,
    input  logic        rst_n,
    input  prf_rd_req_t rd_req [read_port],
    output data_t       rd_data [read_port],
    input  prf_wr_req_t wr_req [write_port],
    input  preg_t       map_reg [32],
    input  areg_t       arch_raddr,
    output data_t       arch_rdata,
    output logic        ready
);

    // flop copy of every physical register for the architectural view
    data_t shadow [preg_size];

    mpram #(
        .read_port (read_port),
        .write_port(write_port),
        .depth     (preg_size),
        .bank_size (preg_size / 2)
    ) ram_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd_req (rd_req),
        .rd_data(rd_data),
        .wr_req (wr_req),
        .ready  (ready)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < preg_size; p++) begin
                shadow[p] <= '0;
            end
        end else if (ready) begin  // same gating as the ram
            for (int w = 0; w < write_port; w++) begin
                if (wr_req[w].we) begin
                    shadow[wr_req[w].addr] <= wr_req[w].data;  // last port wins
                end
            end
        end
    end

    // combinational through the committed map
    assign arch_rdata = shadow[map_reg[arch_raddr]];

    for (genvar i = 0; i < write_port; i++) begin : g_wr_pair
        for (genvar j = i + 1; j < write_port; j++) begin : g_wr_other
            a_wr_conflict: assert property (
                @(posedge clk) disable iff (!rst_n)
                (wr_req[i].we && wr_req[j].we && (wr_req[i].addr == wr_req[j].addr))
                |-> (wr_req[i].data == wr_req[j].data)
            ) else $warning("write ports %0d and %0d disagree on preg %0d",
                            i, j, wr_req[i].addr);
        end
    end

endmodule

`default_nettype wire

//--- commit_rat.sv
`timescale 1ns/100ps
`default_nettype none

module commit_rat
    import prf_pkg::*;
#(
    parameter int commit_port = 2,
    parameter int preg_size   = 128
) (
    input  logic        clk,
    input  logic        rst_n,
    input  rat_commit_t commit [commit_port],
    output preg_t       map_reg [32]
);

    // committed areg to preg map starts as the identity
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int a = 0; a < 32; a++) begin
                map_reg[a] <= preg_t'(a);
            end
        end else begin
            for (int c = 0; c < commit_port; c++) begin
                if (commit[c].valid) begin
                    map_reg[commit[c].areg] <= commit[c].preg;  // higher port overrides
                end
            end
        end
    end

    for (genvar c = 0; c < commit_port; c++) begin : g_commit_chk
        a_preg_range: assert property (
            @(posedge clk) disable iff (!rst_n)
            commit[c].valid |-> (commit[c].preg < preg_size)
        ) else $error("commit port %0d maps to preg %0d beyond file size",
                      c, commit[c].preg);
    end

endmodule

`default_nettype wire

//--- prf_top.sv
`timescale 1ns/100ps
`default_nettype none

module prf_top
    import prf_pkg::*;
#(
    parameter int read_port   = 4,
    parameter int write_port  = 4,
    parameter int preg_size   = 128,  // even, at most 128
    parameter int commit_port = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  prf_rd_req_t rd_req [read_port],
    output data_t       rd_data [read_port],
    input  prf_wr_req_t wr_req [write_port],
    input  rat_commit_t commit [commit_port],
    input  areg_t       arch_raddr,
    output data_t       arch_rdata,
    output logic        ready
);

    preg_t map_reg [32];

    regfile #(
        .read_port (read_port),
        .write_port(write_port),
        .preg_size (preg_size)
    ) regfile_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_req    (rd_req),
        .rd_data   (rd_data),
        .wr_req    (wr_req),
        .map_reg   (map_reg),
        .arch_raddr(arch_raddr),
        .arch_rdata(arch_rdata),
        .ready     (ready)
    );

    commit_rat #(
        .commit_port(commit_port),
        .preg_size  (preg_size)
    ) commit_rat_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .commit (commit),
        .map_reg(map_reg)
    );

endmodule

`default_nettype wire

//--- tb_prf_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_prf_top
    import prf_pkg::*;
;

    localparam int read_port     = 4;
    localparam int write_port    = 4;
    localparam int preg_size     = 128;
    localparam int commit_port   = 2;
    localparam int ready_timeout = 4 * preg_size;

    logic        clk;
    logic        rst_n;
    prf_rd_req_t rd_req [read_port];
    data_t       rd_data [read_port];
    prf_wr_req_t wr_req [write_port];
    rat_commit_t commit [commit_port];
    areg_t       arch_raddr;
    data_t       arch_rdata;
    logic        ready;

    // reference model
    data_t model_mem [preg_size];
    preg_t model_map [32];
    data_t exp_rd [read_port];

    // stimulus for the next edge and what the DUT currently sees
    prf_rd_req_t nxt_rd [read_port];
    prf_wr_req_t nxt_wr [write_port];
    rat_commit_t nxt_commit [commit_port];
    areg_t       nxt_arch;
    prf_rd_req_t cur_rd [read_port];
    prf_wr_req_t cur_wr [write_port];
    rat_commit_t cur_commit [commit_port];
    areg_t       cur_arch;

    logic ready_seen;  // ready as sampled at the last falling edge
    logic timed_out;
    int   errors;
    int   errors_at_start;
    int   tests_run;
    int   tests_failed;

    prf_top #(
        .read_port  (read_port),
        .write_port (write_port),
        .preg_size  (preg_size),
        .commit_port(commit_port)
    ) prf_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_req    (rd_req),
        .rd_data   (rd_data),
        .wr_req    (wr_req),
        .commit    (commit),
        .arch_raddr(arch_raddr),
        .arch_rdata(arch_rdata),
        .ready     (ready)
    );

    always #20 clk = ~clk;

    task automatic check_value(string name, int idx, data_t got, data_t exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s (index %0d) got 0x%h, expected 0x%h", name, idx, got, exp);
        end
    endtask

    task automatic reset_model();
        for (int p = 0; p < preg_size; p++) begin
            model_mem[p] = '0;
        end
        for (int a = 0; a < 32; a++) begin
            model_map[a] = preg_t'(a);  // identity out of reset
        end
        for (int r = 0; r < read_port; r++) begin
            exp_rd[r] = '0;
        end
    endtask

    // model one edge and drive the next inputs before checking at the falling edge
    task automatic cycle();
        @(posedge clk);
        if (ready_seen) begin
            for (int r = 0; r < read_port; r++) begin
                if (cur_rd[r].en) begin
                    exp_rd[r] = model_mem[cur_rd[r].addr];  // no bypass
                end
            end
            for (int w = 0; w < write_port; w++) begin
                if (cur_wr[w].we) begin
                    model_mem[cur_wr[w].addr] = cur_wr[w].data;  // last port wins
                end
            end
        end
        for (int c = 0; c < commit_port; c++) begin
            if (cur_commit[c].valid) begin
                model_map[cur_commit[c].areg] = cur_commit[c].preg;
            end
        end
        for (int r = 0; r < read_port; r++) begin
            rd_req[r] <= nxt_rd[r];
            cur_rd[r] = nxt_rd[r];
            nxt_rd[r] = '0;
        end
        for (int w = 0; w < write_port; w++) begin
            wr_req[w] <= nxt_wr[w];
            cur_wr[w] = nxt_wr[w];
            nxt_wr[w] = '0;
        end
        for (int c = 0; c < commit_port; c++) begin
            commit[c] <= nxt_commit[c];
            cur_commit[c] = nxt_commit[c];
            nxt_commit[c] = '0;
        end
        arch_raddr <= nxt_arch;
        cur_arch = nxt_arch;
        @(negedge clk);
        ready_seen = ready;
        for (int r = 0; r < read_port; r++) begin
            check_value("rd_data", r, rd_data[r], exp_rd[r]);
        end
        check_value("arch_rdata", cur_arch, arch_rdata, model_mem[model_map[cur_arch]]);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        for (int r = 0; r < read_port; r++) begin
            rd_req[r] <= '0;
            cur_rd[r] = '0;
        end
        for (int w = 0; w < write_port; w++) begin
            wr_req[w] <= '0;
            cur_wr[w] = '0;
        end
        for (int c = 0; c < commit_port; c++) begin
            commit[c] <= '0;
            cur_commit[c] = '0;
        end
        reset_model();
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            @(negedge clk);
            ready_seen = ready;
            if (ready !== 1'b0) begin
                errors++;
                $display("error: ready got 0x%h, expected 0x0", ready);
            end
            for (int r = 0; r < read_port; r++) begin
                check_value("rd_data", r, rd_data[r], '0);
            end
        end
        @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready_seen && n < ready_timeout) begin
            cycle();
            n++;
        end
        if (!ready_seen) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: ready did not rise within %0d cycles of reset", ready_timeout);
        end
    endtask

    task automatic start_test();
        errors_at_start = errors;
    endtask

    task automatic finish_test(string name);
        tests_run++;
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errors_at_start);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic test_reset_clear();
        start_test();
        apply_reset();
        wait_ready();
        if (!timed_out) begin
            for (int k = 0; k < preg_size / read_port; k++) begin
                for (int r = 0; r < read_port; r++) begin
                    nxt_rd[r] = '{en: 1'b1, addr: preg_t'(k * read_port + r)};
                end
                cycle();
            end
            for (int a = 0; a < 32; a++) begin
                nxt_arch = areg_t'(a);
                cycle();
                check_value("arch_rdata", a, arch_rdata, '0);
            end
        end
        finish_test("reset_clear");
    endtask

    task automatic test_write_read();
        start_test();
        for (int k = 0; k < 8; k++) begin
            for (int w = 0; w < write_port; w++) begin
                nxt_wr[w] = '{we: 1'b1, addr: preg_t'(8 + 4 * k + w),
                              data: data_t'({$urandom, $urandom})};
            end
            cycle();
        end
        for (int k = 0; k < 8; k++) begin
            for (int r = 0; r < read_port; r++) begin
                nxt_rd[r] = '{en: 1'b1, addr: preg_t'(8 + 4 * k + (r + 1) % read_port)};
            end
            cycle();
        end
        repeat (3) cycle();  // rd_data holds while en is low
        finish_test("write_read");
    endtask

    task automatic test_priority();
        data_t pdata [write_port];
        data_t new_val;
        start_test();
        for (int w = 0; w < write_port; w++) begin
            pdata[w] = {32'(w + 1), $urandom};
            nxt_wr[w] = '{we: 1'b1, addr: preg_t'(50), data: pdata[w]};
        end
        cycle();
        nxt_rd[2] = '{en: 1'b1, addr: preg_t'(50)};
        cycle();
        cycle();
        check_value("rd_data", 2, rd_data[2], pdata[write_port-1]);
        // write and read the same address at one edge
        new_val = {$urandom, $urandom};
        nxt_wr[0] = '{we: 1'b1, addr: preg_t'(50), data: new_val};
        nxt_rd[0] = '{en: 1'b1, addr: preg_t'(50)};
        cycle();
        nxt_rd[0] = '{en: 1'b1, addr: preg_t'(50)};
        cycle();
        check_value("rd_data", 0, rd_data[0], pdata[write_port-1]);
        cycle();
        check_value("rd_data", 0, rd_data[0], new_val);
        finish_test("priority");
    endtask

    task automatic test_commit_map();
        data_t wdata;
        start_test();
        for (int a = 0; a < 32; a++) begin
            nxt_arch = areg_t'(a);
            cycle();
            check_value("arch_rdata", a, arch_rdata, model_mem[a]);
        end
        nxt_commit[0] = '{valid: 1'b1, areg: areg_t'(3), preg: preg_t'(20)};
        nxt_commit[1] = '{valid: 1'b1, areg: areg_t'(7), preg: preg_t'(21)};
        nxt_arch = areg_t'(3);
        cycle();
        nxt_commit[0] = '{valid: 1'b1, areg: areg_t'(5), preg: preg_t'(30)};
        nxt_commit[1] = '{valid: 1'b1, areg: areg_t'(5), preg: preg_t'(50)};
        nxt_arch = areg_t'(5);
        cycle();
        cycle();
        check_value("arch_rdata", 5, arch_rdata, model_mem[50]);
        // every port writes preg 50, now seen through areg 5
        wdata = '0;
        for (int w = 0; w < write_port; w++) begin
            wdata = {32'(w + 1), $urandom};
            nxt_wr[w] = '{we: 1'b1, addr: preg_t'(50), data: wdata};
        end
        nxt_arch = areg_t'(5);
        cycle();
        cycle();
        check_value("arch_rdata", 5, arch_rdata, wdata);
        for (int a = 0; a < 32; a++) begin
            nxt_arch = areg_t'(a);
            cycle();
        end
        finish_test("commit_map");
    endtask

    task automatic test_random();
        start_test();
        for (int i = 0; i < 200; i++) begin
            for (int w = 0; w < write_port; w++) begin
                // ports use disjoint address sets
                nxt_wr[w].we   = ($urandom % 2) == 1;
                nxt_wr[w].addr = preg_t'(($urandom % 32) * 4 + w);
                nxt_wr[w].data = data_t'({$urandom, $urandom});
            end
            for (int r = 0; r < read_port; r++) begin
                nxt_rd[r].en   = ($urandom % 2) == 1;
                nxt_rd[r].addr = preg_t'($urandom % preg_size);
            end
            for (int c = 0; c < commit_port; c++) begin
                nxt_commit[c].valid = ($urandom % 4) == 0;
                nxt_commit[c].areg  = areg_t'($urandom % 32);
                nxt_commit[c].preg  = preg_t'($urandom % preg_size);
            end
            nxt_arch = areg_t'($urandom % 32);
            cycle();
        end
        cycle();
        finish_test("random");
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        arch_raddr   = '0;
        nxt_arch     = '0;
        cur_arch     = '0;
        ready_seen   = 1'b0;
        timed_out    = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int r = 0; r < read_port; r++) begin
            rd_req[r] = '0;
            nxt_rd[r] = '0;
        end
        for (int w = 0; w < write_port; w++) begin
            wr_req[w] = '0;
            nxt_wr[w] = '0;
        end
        for (int c = 0; c < commit_port; c++) begin
            commit[c] = '0;
            nxt_commit[c] = '0;
        end
        void'($urandom(32'hc6540da4));

        test_reset_clear();
        if (!timed_out) begin
            test_write_read();
            test_priority();
            test_commit_map();
            test_random();
        end

        $display("summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed,
                 errors);
        if (errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
prf_pkg.sv
mpram.sv
regfile.sv
commit_rat.sv
prf_top.sv
tb_prf_top.sv

//--- Makefile
# Verilator build and run for the physical register file testbench

VERILATOR ?= verilator
TOP       ?= tb_prf_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -qx "test passed" $(LOG); then \
		echo "simulation ok"; \
	else \
		echo "simulation reported a failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
